//--- camera_control.f
+incdir+hdl
hdl/camera_consts_pkg.sv
hdl/command_decode.sv
hdl/frame_meter.sv
hdl/response_select.sv
hdl/camera_control.sv
testbench/camera_control_tb.sv

//--- hdl/camera_consts.svh
// Window size and average shift must keep the 16-bit sum of 8-bit pixels from overflowing
`ifndef CAMERA_CONSTS_SVH
`define CAMERA_CONSTS_SVH

`define CAMERA_WINDOW_WIDTH     16
`define CAMERA_WINDOW_HEIGHT    16
`define CAMERA_AVERAGE_SHIFT    8   // log2 of window area
`define CAMERA_SUM_WIDTH        16

`define CAMERA_DEFAULT_X_START  0
`define CAMERA_DEFAULT_Y_START  0

`define CAMERA_OP_START_CAPTURE 8'h10
`define CAMERA_OP_SET_X_START   8'h11
`define CAMERA_OP_SET_Y_START   8'h12
`define CAMERA_OP_READ_STATUS   8'h20
`define CAMERA_OP_READ_AVERAGE  8'h21
`define CAMERA_OP_READ_PEAK     8'h22

`endif

//--- hdl/camera_consts_pkg.sv
// Opcode enum values follow the header macros and must stay unique 8-bit codes
`include "camera_consts.svh"

package camera_pkg;

    typedef enum logic [7:0] {
        CMD_START_CAPTURE = `CAMERA_OP_START_CAPTURE,
        CMD_SET_X_START   = `CAMERA_OP_SET_X_START,
        CMD_SET_Y_START   = `CAMERA_OP_SET_Y_START,
        CMD_READ_STATUS   = `CAMERA_OP_READ_STATUS,
        CMD_READ_AVERAGE  = `CAMERA_OP_READ_AVERAGE,
        CMD_READ_PEAK     = `CAMERA_OP_READ_PEAK
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        READ_STATUS,
        READ_AVERAGE,
        READ_PEAK
    } read_select_e;

    typedef enum logic {
        DECODE_OPCODE,
        DECODE_OPERAND   // Set opcode seen, operand pending
    } decode_state_e;

    typedef enum logic [1:0] {
        METER_IDLE,
        METER_ARMED,     // Waiting for frame start
        METER_ACTIVE
    } meter_state_e;

endpackage

//--- hdl/camera_control.sv
// Everything runs on mipi_byte_clock and neither commands nor responses accept back-pressure
`timescale 1ns/1ps

module camera_control (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic [7:0] op_code_i,
    input  logic       op_code_valid_i,
    input  logic [7:0] operand_i,
    input  logic       operand_valid_i,
    input  logic [7:0] pixel_data_i,
    input  logic       line_valid_i,
    input  logic       frame_valid_i,
    output logic [7:0] response_o,
    output logic       response_valid_o
);

    logic                     start_capture;
    logic [7:0]               x_start;
    logic [7:0]               y_start;
    logic                     read_strobe;
    camera_pkg::read_select_e read_select;
    logic                     meter_ready;
    logic [7:0]               average;
    logic [7:0]               peak;

    command_decode i_command_decode (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_i         (operand_i),
        .operand_valid_i   (operand_valid_i),
        .start_capture_o   (start_capture),
        .x_start_o         (x_start),
        .y_start_o         (y_start),
        .read_strobe_o     (read_strobe),
        .read_select_o     (read_select)
    );

    frame_meter i_frame_meter (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .start_capture_i   (start_capture),
        .x_start_i         (x_start),
        .y_start_i         (y_start),
        .pixel_data_i      (pixel_data_i),
        .line_valid_i      (line_valid_i),
        .frame_valid_i     (frame_valid_i),
        .meter_ready_o     (meter_ready),
        .average_o         (average),
        .peak_o            (peak)
    );

    response_select i_response_select (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .read_strobe_i     (read_strobe),
        .read_select_i     (read_select),
        .meter_ready_i     (meter_ready),
        .average_i         (average),
        .peak_i            (peak),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

endmodule

//--- hdl/command_decode.sv
// A new opcode strobe drops any pending set and operands arriving with an opcode are lost
`timescale 1ns/1ps
`include "camera_consts.svh"

module command_decode (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  logic [7:0]                op_code_i,
    input  logic                      op_code_valid_i,
    input  logic [7:0]                operand_i,
    input  logic                      operand_valid_i,
    output logic                      start_capture_o,
    output logic [7:0]                x_start_o,
    output logic [7:0]                y_start_o,
    output logic                      read_strobe_o,
    output camera_pkg::read_select_e  read_select_o
);

    camera_pkg::cmd_opcode_e   op_code;
    camera_pkg::decode_state_e state;
    logic                      pending_y;   // Pending operand targets y_start

    assign op_code = camera_pkg::cmd_opcode_e'(op_code_i);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state           <= camera_pkg::DECODE_OPCODE;
            pending_y       <= 1'b0;
            start_capture_o <= 1'b0;
            x_start_o       <= 8'(`CAMERA_DEFAULT_X_START);
            y_start_o       <= 8'(`CAMERA_DEFAULT_Y_START);
            read_strobe_o   <= 1'b0;
            read_select_o   <= camera_pkg::READ_STATUS;
        end else begin
            start_capture_o <= 1'b0;
            read_strobe_o   <= 1'b0;

            if (op_code_valid_i) begin
                state <= camera_pkg::DECODE_OPCODE;
                case (op_code)
                    camera_pkg::CMD_START_CAPTURE: start_capture_o <= 1'b1;
                    camera_pkg::CMD_SET_X_START: begin
                        state     <= camera_pkg::DECODE_OPERAND;
                        pending_y <= 1'b0;
                    end
                    camera_pkg::CMD_SET_Y_START: begin
                        state     <= camera_pkg::DECODE_OPERAND;
                        pending_y <= 1'b1;
                    end
                    camera_pkg::CMD_READ_STATUS: begin
                        read_strobe_o <= 1'b1;
                        read_select_o <= camera_pkg::READ_STATUS;
                    end
                    camera_pkg::CMD_READ_AVERAGE: begin
                        read_strobe_o <= 1'b1;
                        read_select_o <= camera_pkg::READ_AVERAGE;
                    end
                    camera_pkg::CMD_READ_PEAK: begin
                        read_strobe_o <= 1'b1;
                        read_select_o <= camera_pkg::READ_PEAK;
                    end
                    default: ;   // Unknown opcode ignored
                endcase
            end else if (operand_valid_i && state == camera_pkg::DECODE_OPERAND) begin
                if (pending_y) begin
                    y_start_o <= operand_i;
                end else begin
                    x_start_o <= operand_i;
                end
                state <= camera_pkg::DECODE_OPCODE;
            end
        end
    end

endmodule

//--- hdl/frame_meter.sv
// Pixels on the first frame_valid cycle are not counted and arming mid-frame meters the remainder
`timescale 1ns/1ps
`include "camera_consts.svh"

module frame_meter (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       start_capture_i,
    input  logic [7:0] x_start_i,
    input  logic [7:0] y_start_i,
    input  logic [7:0] pixel_data_i,
    input  logic       line_valid_i,
    input  logic       frame_valid_i,
    output logic       meter_ready_o,
    output logic [7:0] average_o,
    output logic [7:0] peak_o
);

    localparam logic [8:0] POS_MAX = '1;   // Beyond any window end

    camera_pkg::meter_state_e     state;
    logic [8:0]                   column;
    logic [8:0]                   row;
    logic                         line_valid_d;
    logic [7:0]                   x_origin;
    logic [7:0]                   y_origin;
    logic [8:0]                   x_end;
    logic [8:0]                   y_end;
    logic                         pixel_hit;
    logic [`CAMERA_SUM_WIDTH-1:0] sum;
    logic [7:0]                   peak_acc;
    logic                         frame_done;

    always_comb begin
        x_end     = {1'b0, x_origin} + 9'(`CAMERA_WINDOW_WIDTH);
        y_end     = {1'b0, y_origin} + 9'(`CAMERA_WINDOW_HEIGHT);
        pixel_hit = line_valid_i &&
                    column >= {1'b0, x_origin} && column < x_end &&
                    row >= {1'b0, y_origin} && row < y_end;
    end

    // Position in frame, tracked regardless of meter state
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column       <= '0;
            row          <= '0;
            line_valid_d <= 1'b0;
        end else begin
            line_valid_d <= line_valid_i;
            if (!line_valid_i) begin
                column <= '0;
            end else if (column != POS_MAX) begin
                column <= column + 9'd1;
            end
            if (!frame_valid_i) begin
                row <= '0;
            end else if (line_valid_d && !line_valid_i && row != POS_MAX) begin
                row <= row + 9'd1;   // Falling edge of line_valid
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state         <= camera_pkg::METER_IDLE;
            x_origin      <= 8'(`CAMERA_DEFAULT_X_START);
            y_origin      <= 8'(`CAMERA_DEFAULT_Y_START);
            sum           <= '0;
            peak_acc      <= '0;
            frame_done    <= 1'b0;
            meter_ready_o <= 1'b0;
            average_o     <= '0;
            peak_o        <= '0;
        end else begin
            frame_done <= 1'b0;
            if (frame_done) begin
                meter_ready_o <= 1'b1;
            end

            if (start_capture_i) begin
                state         <= camera_pkg::METER_ARMED;
                meter_ready_o <= 1'b0;
            end else begin
                case (state)
                    camera_pkg::METER_ARMED: begin
                        if (frame_valid_i) begin
                            state    <= camera_pkg::METER_ACTIVE;
                            x_origin <= x_start_i;
                            y_origin <= y_start_i;
                            sum      <= '0;
                            peak_acc <= '0;
                        end
                    end
                    camera_pkg::METER_ACTIVE: begin
                        if (!frame_valid_i) begin
                            state      <= camera_pkg::METER_IDLE;
                            average_o  <= 8'(sum >> `CAMERA_AVERAGE_SHIFT);
                            peak_o     <= peak_acc;
                            frame_done <= 1'b1;
                        end else if (pixel_hit) begin
                            sum <= sum + `CAMERA_SUM_WIDTH'(pixel_data_i);
                            if (pixel_data_i > peak_acc) begin
                                peak_acc <= pixel_data_i;
                            end
                        end
                    end
                    default: ;   // Idle frames ignored
                endcase
            end
        end
    end

endmodule

//--- hdl/response_select.sv
// One response per read strobe with no back-pressure and the byte holds until the next read
`timescale 1ns/1ps

module response_select (
    input  logic                     mipi_byte_clock,
    input  logic                     mipi_byte_reset_n,
    input  logic                     read_strobe_i,
    input  camera_pkg::read_select_e read_select_i,
    input  logic                     meter_ready_i,
    input  logic [7:0]               average_i,
    input  logic [7:0]               peak_i,
    output logic [7:0]               response_o,
    output logic                     response_valid_o
);

    logic [7:0] selected;

    always_comb begin
        case (read_select_i)
            camera_pkg::READ_STATUS:  selected = {7'b0, meter_ready_i};
            camera_pkg::READ_AVERAGE: selected = average_i;
            camera_pkg::READ_PEAK:    selected = peak_i;
            default:                  selected = 8'h00;
        endcase
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            response_o       <= 8'h00;
            response_valid_o <= 1'b0;
        end else begin
            response_valid_o <= read_strobe_i;
            if (read_strobe_i) begin
                response_o <= selected;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and fail when the log reports failed checks
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module camera_control_tb \
    -f camera_control.f -o camera_control_sim

./obj_dir/camera_control_sim > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- testbench/camera_control_tb.sv
// Frames are 32x24 with blanking between lines and pixels come from $random with a fixed seed
`timescale 1ns/1ps
`include "camera_consts.svh"

module camera_control_tb;

    localparam int FRAME_WIDTH  = 32;
    localparam int FRAME_HEIGHT = 24;
    localparam int LINE_GAP     = 4;
    localparam int FRAME_GAP    = 8;
    localparam int READ_LATENCY = 2;
    localparam int READ_TIMEOUT = 20;
    localparam int POLL_LIMIT   = 50;

    logic       mipi_byte_clock = 1'b0;
    logic       mipi_byte_reset_n;
    logic [7:0] op_code_i;
    logic       op_code_valid_i;
    logic [7:0] operand_i;
    logic       operand_valid_i;
    logic [7:0] pixel_data_i;
    logic       line_valid_i;
    logic       frame_valid_i;
    logic [7:0] response_o;
    logic       response_valid_o;

    integer seed;
    int     mismatch_count;
    int     failure_count;
    int     model_sum;    // Window sum of the last frame sent
    int     model_peak;

    camera_control i_camera_control (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_i         (operand_i),
        .operand_valid_i   (operand_valid_i),
        .pixel_data_i      (pixel_data_i),
        .line_valid_i      (line_valid_i),
        .frame_valid_i     (frame_valid_i),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

    always #10 mipi_byte_clock = ~mipi_byte_clock;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s: expected 0x%0h actual 0x%0h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic send_command(input logic [7:0] op, input bit with_operand,
                                input logic [7:0] operand);
        @(negedge mipi_byte_clock);
        op_code_i       = op;
        op_code_valid_i = 1'b1;
        @(negedge mipi_byte_clock);
        op_code_valid_i = 1'b0;
        if (with_operand) begin
            operand_i       = operand;
            operand_valid_i = 1'b1;
            @(negedge mipi_byte_clock);
            operand_valid_i = 1'b0;
        end
    endtask

    task automatic send_operand(input logic [7:0] operand);
        @(negedge mipi_byte_clock);
        operand_i       = operand;
        operand_valid_i = 1'b1;
        @(negedge mipi_byte_clock);
        operand_valid_i = 1'b0;
    endtask

    // Also checks the 2-cycle latency and the single-cycle strobe
    task automatic read_byte(input string name, input logic [7:0] op, output logic [7:0] value);
        int cycles;
        cycles = 1;   // Opcode cycle counts as the first
        value  = 8'h00;
        @(negedge mipi_byte_clock);
        op_code_i       = op;
        op_code_valid_i = 1'b1;
        @(negedge mipi_byte_clock);
        op_code_valid_i = 1'b0;
        while (!response_valid_o && cycles < READ_TIMEOUT) begin
            @(negedge mipi_byte_clock);
            cycles++;
        end
        if (!response_valid_o) begin
            $display("Timeout in %s: no response to opcode 0x%02h within %0d cycles",
                     name, op, READ_TIMEOUT);
            failure_count++;
        end else begin
            value = response_o;
            check_value({name, "_latency"}, READ_LATENCY, cycles);
            @(negedge mipi_byte_clock);
            if (response_valid_o) begin
                $display("Failure in %s: response_valid_o stayed high past one cycle", name);
                failure_count++;
            end
        end
    endtask

    task automatic send_frame(input int x, input int y);
        logic [31:0] rand_word;
        model_sum  = 0;
        model_peak = 0;
        @(negedge mipi_byte_clock);
        frame_valid_i = 1'b1;
        repeat (FRAME_GAP) @(negedge mipi_byte_clock);
        for (int row = 0; row < FRAME_HEIGHT; row++) begin
            for (int col = 0; col < FRAME_WIDTH; col++) begin
                rand_word    = $random(seed);
                pixel_data_i = rand_word[7:0];
                line_valid_i = 1'b1;
                if (col >= x && col < x + `CAMERA_WINDOW_WIDTH &&
                    row >= y && row < y + `CAMERA_WINDOW_HEIGHT) begin
                    model_sum += int'(rand_word[7:0]);
                    if (int'(rand_word[7:0]) > model_peak) begin
                        model_peak = int'(rand_word[7:0]);
                    end
                end
                @(negedge mipi_byte_clock);
            end
            line_valid_i = 1'b0;
            pixel_data_i = 8'h00;
            repeat (LINE_GAP) @(negedge mipi_byte_clock);
        end
        repeat (FRAME_GAP) @(negedge mipi_byte_clock);
        frame_valid_i = 1'b0;
        repeat (FRAME_GAP) @(negedge mipi_byte_clock);
    endtask

    task automatic wait_ready(input string name);
        logic [7:0] status;
        int         polls;
        status = 8'h00;
        polls  = 0;
        while (status != 8'h01 && polls < POLL_LIMIT) begin
            read_byte(name, `CAMERA_OP_READ_STATUS, status);
            polls++;
        end
        if (status != 8'h01) begin
            $display("Timeout in %s: status never reported a finished frame", name);
            failure_count++;
        end
    endtask

    // Average is always the window sum over 256, even for a clipped window
    task automatic check_results(input string name);
        logic [7:0] value;
        read_byte(name, `CAMERA_OP_READ_AVERAGE, value);
        check_value({name, "_average"}, (model_sum % 65536) >> `CAMERA_AVERAGE_SHIFT,
                    int'(value));
        read_byte(name, `CAMERA_OP_READ_PEAK, value);
        check_value({name, "_peak"}, model_peak, int'(value));
    endtask

    task automatic capture_and_check(input string name, input int x, input int y);
        send_command(`CAMERA_OP_START_CAPTURE, 1'b0, 8'h00);
        send_frame(x, y);
        wait_ready(name);
        check_results(name);
    endtask

    task automatic idle_after_reset();
        logic [7:0] value;
        repeat (10) begin
            @(negedge mipi_byte_clock);
            if (response_valid_o) begin
                $display("Failure in idle_after_reset: response without any command");
                failure_count++;
            end
        end
        read_byte("idle_status", `CAMERA_OP_READ_STATUS, value);
        check_value("idle_status", 0, int'(value));
    endtask

    task automatic moved_window();
        send_command(`CAMERA_OP_SET_X_START, 1'b1, 8'd10);
        send_command(`CAMERA_OP_SET_Y_START, 1'b1, 8'd5);
        capture_and_check("moved_window", 10, 5);
        send_command(`CAMERA_OP_SET_X_START, 1'b1, 8'd24);   // Half outside the frame
        capture_and_check("clipped_window", 24, 5);
    endtask

    task automatic unarmed_frame();
        int         saved_sum;
        int         saved_peak;
        logic [7:0] value;
        saved_sum  = model_sum;
        saved_peak = model_peak;
        send_frame(0, 0);
        model_sum  = saved_sum;
        model_peak = saved_peak;
        check_results("unarmed_frame");
        read_byte("unarmed_status", `CAMERA_OP_READ_STATUS, value);
        check_value("unarmed_status", 1, int'(value));
        send_command(`CAMERA_OP_START_CAPTURE, 1'b0, 8'h00);
        read_byte("rearmed_status", `CAMERA_OP_READ_STATUS, value);
        check_value("rearmed_status", 0, int'(value));
        send_frame(24, 5);
        wait_ready("rearmed_frame");
        check_results("rearmed_frame");
    endtask

    task automatic command_robustness();
        logic [7:0] value;
        send_command(8'h55, 1'b0, 8'h00);
        repeat (10) begin
            @(negedge mipi_byte_clock);
            if (response_valid_o) begin
                $display("Failure in command_robustness: unknown opcode gave a response");
                failure_count++;
            end
        end
        send_command(`CAMERA_OP_SET_X_START, 1'b1, 8'd3);
        send_command(`CAMERA_OP_SET_Y_START, 1'b1, 8'd2);
        send_command(`CAMERA_OP_SET_X_START, 1'b0, 8'h00);   // Left pending
        read_byte("interrupt_status", `CAMERA_OP_READ_STATUS, value);
        check_value("interrupt_status", 1, int'(value));
        send_operand(8'd40);
        send_operand(8'd50);
        capture_and_check("interrupted_set", 3, 2);
    endtask

    initial begin
        seed              = 29180;
        mismatch_count    = 0;
        failure_count     = 0;
        model_sum         = 0;
        model_peak        = 0;
        mipi_byte_reset_n = 1'b0;
        op_code_i         = 8'h00;
        op_code_valid_i   = 1'b0;
        operand_i         = 8'h00;
        operand_valid_i   = 1'b0;
        pixel_data_i      = 8'h00;
        line_valid_i      = 1'b0;
        frame_valid_i     = 1'b0;
        repeat (10) @(negedge mipi_byte_clock);
        mipi_byte_reset_n = 1'b1;
        @(negedge mipi_byte_clock);

        idle_after_reset();
        capture_and_check("default_window", 0, 0);
        moved_window();
        unarmed_frame();
        command_robustness();

        $display("Value mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
